// ==== verilog/csa_pkg.sv ====
`default_nettype none

package csa_pkg;

  // Adder geometry
  // One skip group per pipeline stage, so the group count is also the depth

  // Bits handled by one ripple group
  localparam int unsigned CSA_GROUP_W = 4;

  // Skip groups with one register stage each
  localparam int unsigned CSA_GROUPS = 4;

  // Full operand width
  localparam int unsigned CSA_WIDTH = CSA_GROUP_W * CSA_GROUPS;

  // Operand and result types

  // Whole operand or whole sum
  typedef logic [CSA_WIDTH-1:0] csa_word_t;

  // One group's share of an operand or sum
  typedef logic [CSA_GROUP_W-1:0] csa_slice_t;

  // Pipeline lane
  // Everything one addition needs as it moves from stage to stage.
  // Operands ride along unchanged and each stage reads only its own slice.
  // The sum fills in from the low slice upward, one slice per stage.
  // Carry is the carry into the group of the next stage.
  typedef struct packed {
    // Marks a live addition in this stage register
    logic      valid;
    // First addend
    csa_word_t op_a;
    // Second addend
    csa_word_t op_b;
    // Partial sum with the upper slices still cleared
    csa_word_t sum;
    // Carry into the next group or the adder carry-out after the last stage
    logic      carry;
  } csa_lane_t;

endpackage : csa_pkg

`default_nettype wire

// ==== verilog/csa_group.sv ====
`default_nettype none

module csa_group (
  input  csa_pkg::csa_slice_t i_add_term1,
  input  csa_pkg::csa_slice_t i_add_term2,
  input  logic                i_cin,
  output csa_pkg::csa_slice_t o_sum,
  output logic                o_cin_next
);

  import csa_pkg::*;

  // Per-bit generate and propagate
  csa_slice_t bit_gen;
  csa_slice_t bit_prop;

  // Ripple carries, entry 0 is the group carry-in
  logic [CSA_GROUP_W:0] ripple_carry;

  // Carry-out of the last full adder
  logic ripple_cout;

  // Whole group propagates
  logic grp_prop;

  // Mux legs
  logic skip_leg;
  logic ripple_leg;

  // Half-adder terms
  // XOR doubles as the propagate term of the skip detector
  assign bit_gen  = i_add_term1 & i_add_term2;
  assign bit_prop = i_add_term1 ^ i_add_term2;

  // Ripple-carry adder
  // Four full adders chained LSB first
  always_comb begin
    ripple_carry[0] = i_cin;
    for (int i = 0; i < CSA_GROUP_W; i++) begin
      // Sum bit from propagate and incoming carry
      o_sum[i] = bit_prop[i] ^ ripple_carry[i];
      // Carry out: generate, or propagate an incoming carry
      ripple_carry[i+1] = bit_gen[i] | (bit_prop[i] & ripple_carry[i]);
    end
  end

  assign ripple_cout = ripple_carry[CSA_GROUP_W];

  // Group propagate detector
  // AND of every per-bit XOR, so a carry in would run straight through
  assign grp_prop = &bit_prop;

  // Skip multiplexer
  // Select high passes i_cin around the ripple chain,
  // select low takes the ripple carry-out
  // Written as the and-or pair of a two-input mux
  assign skip_leg   = i_cin & grp_prop;
  assign ripple_leg = ripple_cout & ~grp_prop;

  assign o_cin_next = skip_leg | ripple_leg;

endmodule : csa_group

`default_nettype wire

// ==== verilog/csa_stage.sv ====
`default_nettype none

module csa_stage #(
  parameter int unsigned STAGE_INDEX = 0
) (
  input  logic               i_clk,
  input  logic               i_rst,
  input  csa_pkg::csa_lane_t i_lane,
  output csa_pkg::csa_lane_t o_lane
);

  import csa_pkg::*;

  // Lowest bit of this stage's slice
  localparam int unsigned SLICE_LO = STAGE_INDEX * CSA_GROUP_W;

  // Bits of the sum word owned by this stage
  localparam csa_word_t SLICE_MASK = csa_word_t'({CSA_GROUP_W{1'b1}}) << SLICE_LO;

  // Operand slices for this group
  csa_slice_t slice_a;
  csa_slice_t slice_b;

  // Group results
  csa_slice_t grp_sum;
  logic       grp_cout;

  // Group sum moved to its place in a full word
  csa_word_t  sum_placed;

  // Lane after this stage's update
  csa_lane_t  lane_d;

  // Registered lane toward the next stage
  csa_lane_t  lane_q;

  // Pick this group's slice out of the operands
  assign slice_a = i_lane.op_a[SLICE_LO +: CSA_GROUP_W];
  assign slice_b = i_lane.op_b[SLICE_LO +: CSA_GROUP_W];

  // Carry-skip group
  // Incoming carry is the previous stage's skip output
  csa_group u_group (
    .i_add_term1 (slice_a),
    .i_add_term2 (slice_b),
    .i_cin       (i_lane.carry),
    .o_sum       (grp_sum),
    .o_cin_next  (grp_cout)
  );

  // Zero-extend and shift into position
  assign sum_placed = {{(CSA_WIDTH - CSA_GROUP_W){1'b0}}, grp_sum} << SLICE_LO;

  // Lane update
  // Operands and valid pass through untouched
  always_comb begin
    lane_d       = i_lane;
    // Replace only this stage's slice of the sum
    lane_d.sum   = (i_lane.sum & ~SLICE_MASK) | sum_placed;
    // Carry for the next group comes from the skip mux
    lane_d.carry = grp_cout;
  end

  // Stage register
  // Loads on every edge and reset drops only valid
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      lane_q.valid <= 1'b0;
    end else begin
      lane_q.valid <= lane_d.valid;
    end
    // Data follows the lane whether or not it is valid
    lane_q.op_a  <= lane_d.op_a;
    lane_q.op_b  <= lane_d.op_b;
    lane_q.sum   <= lane_d.sum;
    lane_q.carry <= lane_d.carry;
  end

  assign o_lane = lane_q;

endmodule : csa_stage

`default_nettype wire

// ==== verilog/csa_adder_top.sv ====
`default_nettype none

module csa_adder_top (
  input  logic               i_clk,
  input  logic               i_rst,
  // Operand strobe, no handshake
  input  logic               i_valid,
  input  csa_pkg::csa_word_t i_op_a,
  input  csa_pkg::csa_word_t i_op_b,
  input  logic               i_cin,
  // Result strobe, high for exactly one cycle per addition
  output logic               o_valid,
  output csa_pkg::csa_word_t o_sum,
  output logic               o_cout
);

  import csa_pkg::*;

  // Lane chain
  // Entry 0 is the unregistered input lane,
  // entry k+1 is the register output of stage k
  csa_lane_t lane_chain [0:CSA_GROUPS];

  // Last registered lane
  csa_lane_t lane_out;

  // Entry lane
  // Sum starts cleared, each stage fills one slice
  always_comb begin
    lane_chain[0].valid = i_valid;
    lane_chain[0].op_a  = i_op_a;
    lane_chain[0].op_b  = i_op_b;
    lane_chain[0].sum   = '0;
    // Carry into group 0 is the external carry-in
    lane_chain[0].carry = i_cin;
  end

  // Pipeline stages
  // One skip group per stage, carry crosses stages through the lane register
  for (genvar k = 0; k < CSA_GROUPS; k++) begin : g_stage
    csa_stage #(
      .STAGE_INDEX (k)
    ) u_stage (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .i_lane (lane_chain[k]),
      .o_lane (lane_chain[k+1])
    );
  end

  assign lane_out = lane_chain[CSA_GROUPS];

  // Result unpack
  // Straight from the last stage register, four cycles after entry
  assign o_valid = lane_out.valid;
  assign o_sum   = lane_out.sum;
  // Skip output of the top group is the adder carry-out
  assign o_cout  = lane_out.carry;

endmodule : csa_adder_top

`default_nettype wire

// ==== dv/csa_adder_vectors.svh ====
`ifndef CSA_ADDER_VECTORS_SVH
`define CSA_ADDER_VECTORS_SVH

// Columns: test name, op_a, op_b, cin, active
// Active low rows are idle slots, i_valid stays low and the operands are junk

task automatic load_directed_rows();
  // Carries generated and absorbed inside single groups
  add_row("small_3_plus_5",     16'h0003, 16'h0005, 1'b0, 1'b1);
  add_row("small_with_cin",     16'h0012, 16'h0021, 1'b1, 1'b1);
  add_row("group0_carry_out",   16'h000F, 16'h0001, 1'b0, 1'b1);
  add_row("mixed_groups",       16'h1234, 16'h4321, 1'b0, 1'b1);
  add_row("zero_plus_zero",     16'h0000, 16'h0000, 1'b0, 1'b1);

  // Skip path, whole groups propagate the incoming carry
  add_row("skip_mid_groups",    16'h00F0, 16'h0F00, 1'b1, 1'b1);
  add_row("skip_all_cin0",      16'h5555, 16'hAAAA, 1'b0, 1'b1);
  add_row("skip_all_cin1",      16'h5555, 16'hAAAA, 1'b1, 1'b1);
  add_row("skip_from_group0",   16'h00FF, 16'h0001, 1'b0, 1'b1);
  // Group 0 generates, groups 1 to 3 all propagate
  add_row("skip_three_groups",  16'h000F, 16'hFFF1, 1'b0, 1'b1);
  add_row("skip_alt_nibbles",   16'h0FF0, 16'hF00F, 1'b1, 1'b1);

  // Full-width carry chain and wrap
  add_row("wrap_ffff_plus_1",   16'hFFFF, 16'h0001, 1'b0, 1'b1);
  add_row("max_plus_max_cin",   16'hFFFF, 16'hFFFF, 1'b1, 1'b1);
  add_row("top_bit_carry",      16'h8000, 16'h8000, 1'b0, 1'b1);
  add_row("ffff_plus_cin",      16'hFFFF, 16'h0000, 1'b1, 1'b1);

  // Gapped stream, idle slots in between
  add_row("gap_a",              16'h1357, 16'h2468, 1'b0, 1'b1);
  add_row("idle",               16'hDEAD, 16'hBEEF, 1'b1, 1'b0);
  add_row("gap_b",              16'h7FFF, 16'h0001, 1'b0, 1'b1);
  add_row("idle",               16'hFFFF, 16'hFFFF, 1'b1, 1'b0);
  add_row("idle",               16'h0F0F, 16'hF0F0, 1'b1, 1'b0);
  add_row("gap_c",              16'hF0F0, 16'h0F0F, 1'b1, 1'b1);
  add_row("idle",               16'hA5A5, 16'h5A5A, 1'b0, 1'b0);
  add_row("idle",               16'h8001, 16'h7FFF, 1'b0, 1'b0);
  add_row("idle",               16'hC3C3, 16'h3C3C, 1'b1, 1'b0);
  add_row("gap_d",              16'h4000, 16'hC000, 1'b0, 1'b1);
endtask

`endif

// ==== dv/csa_adder_tb.sv ====
`default_nettype none

module csa_adder_tb;

  import csa_pkg::*;

  // Edges from the edge a row is driven on to the edge that shows its result
  localparam int LATENCY = 4;
  localparam int MAX_ROWS = 64;
  localparam int RAND_ROWS = 16;
  localparam int RST_CYCLES = 5;
  // Cycles the drain loop waits before calling results missing
  localparam int DRAIN_LIMIT = 40;
  localparam logic [31:0] SEED = 32'd24;

  // Sum with the carry-out on top
  typedef logic [CSA_WIDTH:0] result_t;

  // One stimulus row and its expected result
  typedef struct packed {
    logic      active;
    csa_word_t op_a;
    csa_word_t op_b;
    logic      cin;
    result_t   expected;
  } row_t;

  logic      i_clk;
  logic      i_rst;
  logic      i_valid;
  csa_word_t i_op_a;
  csa_word_t i_op_b;
  logic      i_cin;
  logic      o_valid;
  csa_word_t o_sum;
  logic      o_cout;

  // Stimulus table, names kept beside it
  row_t  rows [0:MAX_ROWS-1];
  string row_name [0:MAX_ROWS-1];
  int    row_cnt = 0;

  // Rows in flight, oldest first, with the edge each was driven on
  int pend_idx [$];
  int pend_edge [$];

  int edge_cnt = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  logic [31:0] rng_state = SEED;

  csa_adder_top uut (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_op_a  (i_op_a),
    .i_op_b  (i_op_b),
    .i_cin   (i_cin),
    .o_valid (o_valid),
    .o_sum   (o_sum),
    .o_cout  (o_cout)
  );

  always #5 i_clk = ~i_clk;

  // Rising edges seen so far
  always @(posedge i_clk) edge_cnt <= edge_cnt + 1;

  // Reference model, plain 17-bit addition
  function automatic result_t ref_sum(input csa_word_t a, input csa_word_t b,
                                      input logic cin);
    result_t wide;
    wide = {1'b0, a} + {1'b0, b} + {{CSA_WIDTH{1'b0}}, cin};
    return wide;
  endfunction

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Appends a row, expected value taken from the reference model
  task automatic add_row(input string name, input csa_word_t a, input csa_word_t b,
                         input logic cin, input logic active);
    row_t r;
    if (row_cnt >= MAX_ROWS) begin
      $display("Stimulus table is full, row %s was dropped", name);
      fail_cnt++;
    end else begin
      r.active = active;
      r.op_a = a;
      r.op_b = b;
      r.cin = cin;
      r.expected = ref_sum(a, b, cin);
      rows[row_cnt] = r;
      row_name[row_cnt] = name;
      row_cnt++;
    end
  endtask

  `include "csa_adder_vectors.svh"

  // Back-to-back random rows
  task automatic add_random_rows(input int n, input string prefix);
    csa_word_t a;
    csa_word_t b;
    for (int i = 0; i < n; i++) begin
      rng_state = xorshift32(rng_state);
      a = rng_state[CSA_WIDTH-1:0];
      rng_state = xorshift32(rng_state);
      b = rng_state[CSA_WIDTH-1:0];
      rng_state = xorshift32(rng_state);
      add_row($sformatf("%s_%0d", prefix, i), a, b, rng_state[0], 1'b1);
    end
  endtask

  // Puts one row on the inputs at the next rising edge
  task automatic drive_row(input int idx);
    @(posedge i_clk);
    i_valid <= rows[idx].active;
    i_op_a <= rows[idx].op_a;
    i_op_b <= rows[idx].op_b;
    i_cin <= rows[idx].cin;
    if (rows[idx].active) begin
      pend_idx.push_back(idx);
      // Counter still holds the previous edge here
      pend_edge.push_back(edge_cnt + 1);
    end
  endtask

  task automatic drive_idle();
    @(posedge i_clk);
    i_valid <= 1'b0;
  endtask

  // Waits until every row in flight has come back
  task automatic drain_results();
    int waited;
    waited = 0;
    while (pend_idx.size() > 0 && waited < DRAIN_LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    assert (pend_idx.size() == 0) else begin
      $display("Timed out waiting, %0d results went missing", pend_idx.size());
      fail_cnt += pend_idx.size();
      pend_idx.delete();
      pend_edge.delete();
    end
  endtask

  // Flushes in-flight rows with a reset, o_valid must stay low throughout
  task automatic check_reset();
    int first;
    logic ok;
    first = row_cnt;
    ok = 1'b1;
    add_random_rows(3, "inflight");
    for (int i = first; i < row_cnt; i++) begin
      drive_row(i);
    end
    // Rows in flight are abandoned
    @(posedge i_clk);
    pend_idx.delete();
    pend_edge.delete();
    i_rst <= 1'b1;
    i_valid <= 1'b0;
    repeat (RST_CYCLES) begin
      @(negedge i_clk);
      assert (o_valid === 1'b0) else begin
        $display("o_valid was not low while reset was held");
        ok = 1'b0;
      end
    end
    @(posedge i_clk);
    i_rst <= 1'b0;
    // Nothing may leak out after release either
    repeat (3) begin
      @(negedge i_clk);
      assert (o_valid === 1'b0) else begin
        $display("o_valid went high after reset with no new row driven");
        ok = 1'b0;
      end
    end
    if (ok) begin
      $display("passed reset_flush: in-flight rows dropped, o_valid held low");
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
    // Pipeline must work again after the flush
    first = row_cnt;
    add_row("after_reset_a", 16'h00FF, 16'hFF01, 1'b0, 1'b1);
    add_row("after_reset_b", 16'h1111, 16'h2222, 1'b1, 1'b1);
    for (int i = first; i < row_cnt; i++) begin
      drive_row(i);
    end
    drive_idle();
    drain_results();
  endtask

  // Result checker, outputs are settled at the falling edge
  always @(negedge i_clk) begin : check_result
    int idx;
    int lat;
    result_t got;
    logic row_ok;
    if (o_valid === 1'b1) begin
      assert (pend_idx.size() > 0) else begin
        $display("An unexpected result appeared: sum %04h cout %0b", o_sum, o_cout);
        fail_cnt++;
      end
      if (pend_idx.size() > 0) begin
        idx = pend_idx.pop_front();
        lat = edge_cnt - pend_edge.pop_front();
        got = {o_cout, o_sum};
        row_ok = 1'b1;
        assert (got === rows[idx].expected) else begin
          $display("FAILED %s: expected %05h, got %05h",
                   row_name[idx], rows[idx].expected, got);
          row_ok = 1'b0;
        end
        assert (lat == LATENCY) else begin
          $display("FAILED %s latency: expected %0d, got %0d", row_name[idx], LATENCY, lat);
          row_ok = 1'b0;
        end
        if (row_ok) begin
          $display("passed %s: %04h + %04h + %0b = %05h", row_name[idx],
                   rows[idx].op_a, rows[idx].op_b, rows[idx].cin, got);
          pass_cnt++;
        end else begin
          fail_cnt++;
        end
      end
    end
  end

  initial begin : run_tests
    i_clk = 1'b0;
    i_rst = 1'b1;
    i_valid = 1'b0;
    i_op_a = '0;
    i_op_b = '0;
    i_cin = 1'b0;
    load_directed_rows();
    add_random_rows(RAND_ROWS, "rand");
    repeat (RST_CYCLES) @(posedge i_clk);
    i_rst <= 1'b0;
    // Whole table streamed one row per edge
    for (int i = 0; i < row_cnt; i++) begin
      drive_row(i);
    end
    drive_idle();
    drain_results();
    check_reset();
    $display("Totals: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== csa_adder_top.f ====
+incdir+dv
verilog/csa_pkg.sv
verilog/csa_group.sv
verilog/csa_stage.sv
verilog/csa_adder_top.sv
dv/csa_adder_tb.sv
